// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_mac_attach
FILELIST  = mac_attach_top.f
PASS_MSG  = Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(VFLAGS) --lint-only --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --binary --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== attach_regs.sv ====
/*
 * Register block with strobe access
 * ID, version, control, flip, debug and counter readback
 */
`include "mac_attach_settings.svh"

module attach_regs (
  input  logic                          axis_aclk,
  input  logic                          i_rst_n,
  input  mac_attach_reg_pkg::reg_addr_t i_reg_addr,
  input  logic                          i_reg_wr,
  input  mac_attach_reg_pkg::reg_data_t i_reg_wdata,
  input  logic                          i_reg_rd,
  output mac_attach_reg_pkg::reg_data_t o_reg_rdata,
  output logic                          o_reg_rvalid,
  pkt_stat_if.regs                      stat
);

  localparam int N     = mac_attach_reg_pkg::NUM_STATS;
  localparam int SEL_W = $clog2(N);
  // Pulse bits never stay set in the control register
  localparam mac_attach_reg_pkg::reg_data_t CTRL_PULSE_MASK =
    (32'd1 << mac_attach_reg_pkg::CTRL_CLEAR_COUNTERS_BIT) |
    (32'd1 << mac_attach_reg_pkg::CTRL_RESET_REGS_BIT);

  mac_attach_reg_pkg::reg_data_t ctrl_reg;
  mac_attach_reg_pkg::reg_data_t flip_wr;
  mac_attach_reg_pkg::reg_data_t debug_wr;
  mac_attach_reg_pkg::reg_data_t rd_mux;
  mac_attach_reg_pkg::reg_addr_t cnt_off;
  logic [SEL_W-1:0]              cnt_sel;
  logic                          cnt_hit;
  logic                          ctrl_wr;

  // --------------------------------------------------------------------------
  // Counter address decode
  // --------------------------------------------------------------------------
  assign cnt_off = i_reg_addr - mac_attach_reg_pkg::ADDR_CNT_BASE;
  assign cnt_sel = cnt_off[SEL_W+1:2];
  assign cnt_hit = (i_reg_addr >= mac_attach_reg_pkg::ADDR_CNT_BASE) &&
                   (cnt_off[1:0] == 2'b00) && (cnt_off[7:2] < 6'(N));

  // Counters clear on read, so the pulse goes out with the strobe
  assign stat.read_clear = (i_reg_rd && cnt_hit) ? (N'(1) << cnt_sel) : '0;

  assign ctrl_wr        = i_reg_wr && (i_reg_addr == mac_attach_reg_pkg::ADDR_CONTROL);
  assign stat.clear_all = ctrl_wr && i_reg_wdata[mac_attach_reg_pkg::CTRL_CLEAR_COUNTERS_BIT];

  always_comb begin
    rd_mux = '0;
    case (i_reg_addr)
      mac_attach_reg_pkg::ADDR_ID:      rd_mux = `REG_ID_DEFAULT;
      mac_attach_reg_pkg::ADDR_VERSION: rd_mux = `REG_VERSION_DEFAULT;
      mac_attach_reg_pkg::ADDR_CONTROL: rd_mux = ctrl_reg;
      mac_attach_reg_pkg::ADDR_FLIP:    rd_mux = ~flip_wr;
      mac_attach_reg_pkg::ADDR_DEBUG:   rd_mux = `REG_DEBUG_DEFAULT + debug_wr;
      default: begin
        if (cnt_hit) begin
          rd_mux = 32'(stat.count[cnt_sel]);
        end
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Write side and read response
  // --------------------------------------------------------------------------
  always_ff @(posedge axis_aclk) begin
    if (!i_rst_n) begin
      ctrl_reg     <= '0;
      flip_wr      <= '0;
      debug_wr     <= '0;
      o_reg_rvalid <= 1'b0;
    end else begin
      o_reg_rvalid <= i_reg_rd;
      if (ctrl_wr && i_reg_wdata[mac_attach_reg_pkg::CTRL_RESET_REGS_BIT]) begin
        ctrl_reg <= '0;
        flip_wr  <= '0;
        debug_wr <= '0;
      end else if (i_reg_wr) begin
        case (i_reg_addr)
          mac_attach_reg_pkg::ADDR_CONTROL: ctrl_reg <= i_reg_wdata & ~CTRL_PULSE_MASK;
          mac_attach_reg_pkg::ADDR_FLIP:    flip_wr  <= i_reg_wdata;
          mac_attach_reg_pkg::ADDR_DEBUG:   debug_wr <= i_reg_wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (i_reg_rd) begin
      o_reg_rdata <= rd_mux;
    end
  end

endmodule

// ==== mac_attach_reg_pkg.sv ====
/*
 * Register map of the MAC attachment
 * Addresses, control bits and packet counter types
 */
`include "mac_attach_settings.svh"

package mac_attach_reg_pkg;

  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  localparam reg_addr_t ADDR_ID       = 8'h00;
  localparam reg_addr_t ADDR_VERSION  = 8'h04;
  localparam reg_addr_t ADDR_CONTROL  = 8'h08;
  localparam reg_addr_t ADDR_FLIP     = 8'h0C;
  localparam reg_addr_t ADDR_DEBUG    = 8'h10;
  // Counters follow in steps of 4
  localparam reg_addr_t ADDR_CNT_BASE = 8'h14;

  // Control register bits, both self-clearing
  localparam int CTRL_CLEAR_COUNTERS_BIT = 0;
  localparam int CTRL_RESET_REGS_BIT     = 4;

  // Packet counters in address order
  typedef enum logic [2:0] {
    STAT_RX_MAC,
    STAT_RX_DROP,
    STAT_RX_OUT,
    STAT_TX_IN,
    STAT_TX_MAC
  } stat_idx_t;

  localparam int NUM_STATS = 5;

  typedef logic [`STAT_CNT_WIDTH-1:0] stat_cnt_t;

endpackage

// ==== mac_attach_settings.svh ====
/*
 * MAC attachment settings
 * Widths, queue depths, register constants and counter width
 */
`ifndef MAC_ATTACH_SETTINGS_SVH
`define MAC_ATTACH_SETTINGS_SVH

// Stream widths, same on both sides of the block
`define AXIS_DATA_WIDTH   64
`define AXIS_KEEP_WIDTH   8
`define AXIS_TUSER_WIDTH  128
`define TIMESTAMP_WIDTH   64

// Queue depths in beats
`define RX_QUEUE_DEPTH    16
`define TX_QUEUE_DEPTH    16

// Top bit is the sticky overflow flag
`define STAT_CNT_WIDTH    8

// Register constants
`define REG_ID_DEFAULT       32'h0000_da01
`define REG_VERSION_DEFAULT  32'h0000_0100
`define REG_DEBUG_DEFAULT    32'h0000_0010

`endif

// ==== mac_attach_stimulus.txt ====
# All fields hex. op 1 rx frame: length error seed. op 2 tx frame: length ready_mode seed
# op 3 reg write: addr data 0. op 4 reg read: addr expected 0. op 5 tx burst: count mode seed
1 4 0 38
1 1 0 a1c3
1 3 1 7e55
1 2 0 0b19
4 14 4 0
4 18 1 0
4 1c 3 0
2 5 0 04d2
2 6 1 9e37
4 20 2 0
4 24 2 0
4 0 da01 0
4 4 100 0
3 c 12345678 0
4 c edcba987 0
3 10 5 0
4 10 15 0
3 8 a0 0
4 8 a0 0
3 8 10 0
4 c ffffffff 0
4 10 10 0
4 8 0 0
5 82 0 5a5a
4 20 82 0
4 20 0 0
3 8 1 0
4 24 0 0
4 8 0 0

// ==== mac_attach_stream_pkg.sv ====
/*
 * Stream types for the MAC attachment
 * Beat types and the tuser field layout
 */
`include "mac_attach_settings.svh"

package mac_attach_stream_pkg;

  typedef logic [`AXIS_DATA_WIDTH-1:0]  axis_data_t;
  typedef logic [`AXIS_KEEP_WIDTH-1:0]  axis_keep_t;
  typedef logic [`AXIS_TUSER_WIDTH-1:0] axis_tuser_t;

  // One beat as held in a queue entry
  typedef struct packed {
    axis_data_t  data;
    axis_keep_t  keep;
    axis_tuser_t tuser;
    logic        last;
  } stream_beat_t;

  // --------------------------------------------------------------------------
  // Sideband fields written on the first beat of a received frame
  // --------------------------------------------------------------------------
  localparam int TUSER_SRC_PORT_LSB   = 16;
  localparam int TUSER_SRC_PORT_WIDTH = 8;
  localparam int TUSER_STAMP_LSB      = 32;
  localparam int TUSER_STAMP_WIDTH    = `TIMESTAMP_WIDTH;

endpackage

// ==== mac_attach_top.f ====
+incdir+.
mac_attach_stream_pkg.sv
mac_attach_reg_pkg.sv
pkt_stat_if.sv
rx_frame_queue.sv
tx_frame_queue.sv
pkt_stat_counters.sv
attach_regs.sv
mac_attach_top.sv
tb_mac_attach.sv

// ==== mac_attach_top.sv ====
/*
 * MAC attachment top level
 * Receive and transmit queues, packet counters and registers
 */
`include "mac_attach_settings.svh"

module mac_attach_top (
  input  logic                               axis_aclk,
  input  logic                               i_rst_n,
  // MAC receive
  input  mac_attach_stream_pkg::axis_data_t  i_mac_rx_tdata,
  input  mac_attach_stream_pkg::axis_keep_t  i_mac_rx_tkeep,
  input  mac_attach_stream_pkg::axis_tuser_t i_mac_rx_tuser,
  input  logic                               i_mac_rx_tvalid,
  input  logic                               i_mac_rx_tlast,
  input  logic                               i_mac_rx_err,
  // Pipeline output
  output mac_attach_stream_pkg::axis_data_t  o_pipe_rx_tdata,
  output mac_attach_stream_pkg::axis_keep_t  o_pipe_rx_tkeep,
  output mac_attach_stream_pkg::axis_tuser_t o_pipe_rx_tuser,
  output logic                               o_pipe_rx_tvalid,
  output logic                               o_pipe_rx_tlast,
  input  logic                               i_pipe_rx_tready,
  // Pipeline input
  input  mac_attach_stream_pkg::axis_data_t  i_pipe_tx_tdata,
  input  mac_attach_stream_pkg::axis_keep_t  i_pipe_tx_tkeep,
  input  mac_attach_stream_pkg::axis_tuser_t i_pipe_tx_tuser,
  input  logic                               i_pipe_tx_tvalid,
  input  logic                               i_pipe_tx_tlast,
  output logic                               o_pipe_tx_tready,
  // MAC transmit
  output mac_attach_stream_pkg::axis_data_t  o_mac_tx_tdata,
  output mac_attach_stream_pkg::axis_keep_t  o_mac_tx_tkeep,
  output mac_attach_stream_pkg::axis_tuser_t o_mac_tx_tuser,
  output logic                               o_mac_tx_tvalid,
  output logic                               o_mac_tx_tlast,
  input  logic                               i_mac_tx_tready,
  // Port identity and time base
  input  logic [7:0]                         i_interface_number,
  input  logic [`TIMESTAMP_WIDTH-1:0]        i_stamp_counter,
  // Register access
  input  mac_attach_reg_pkg::reg_addr_t      i_reg_addr,
  input  logic                               i_reg_wr,
  input  mac_attach_reg_pkg::reg_data_t      i_reg_wdata,
  input  logic                               i_reg_rd,
  output mac_attach_reg_pkg::reg_data_t      o_reg_rdata,
  output logic                               o_reg_rvalid
);

  logic [`TIMESTAMP_WIDTH-1:0]              stamp_q;
  logic                                     rx_frame_seen;
  logic                                     rx_frame_drop;
  logic [mac_attach_reg_pkg::NUM_STATS-1:0] stat_event;

  pkt_stat_if stat ();

  always_ff @(posedge axis_aclk) begin
    stamp_q <= i_stamp_counter;
  end

  // --------------------------------------------------------------------------
  // Data paths
  // --------------------------------------------------------------------------
  rx_frame_queue u_rx_queue (
    .axis_aclk          (axis_aclk),
    .i_rst_n            (i_rst_n),
    .i_tdata            (i_mac_rx_tdata),
    .i_tkeep            (i_mac_rx_tkeep),
    .i_tuser            (i_mac_rx_tuser),
    .i_tvalid           (i_mac_rx_tvalid),
    .i_tlast            (i_mac_rx_tlast),
    .i_err              (i_mac_rx_err),
    .i_interface_number (i_interface_number),
    .i_stamp            (stamp_q),
    .o_tdata            (o_pipe_rx_tdata),
    .o_tkeep            (o_pipe_rx_tkeep),
    .o_tuser            (o_pipe_rx_tuser),
    .o_tvalid           (o_pipe_rx_tvalid),
    .o_tlast            (o_pipe_rx_tlast),
    .i_tready           (i_pipe_rx_tready),
    .o_frame_seen       (rx_frame_seen),
    .o_frame_drop       (rx_frame_drop)
  );

  tx_frame_queue u_tx_queue (
    .axis_aclk (axis_aclk),
    .i_rst_n   (i_rst_n),
    .i_tdata   (i_pipe_tx_tdata),
    .i_tkeep   (i_pipe_tx_tkeep),
    .i_tuser   (i_pipe_tx_tuser),
    .i_tvalid  (i_pipe_tx_tvalid),
    .i_tlast   (i_pipe_tx_tlast),
    .o_tready  (o_pipe_tx_tready),
    .o_tdata   (o_mac_tx_tdata),
    .o_tkeep   (o_mac_tx_tkeep),
    .o_tuser   (o_mac_tx_tuser),
    .o_tvalid  (o_mac_tx_tvalid),
    .o_tlast   (o_mac_tx_tlast),
    .i_tready  (i_mac_tx_tready)
  );

  // --------------------------------------------------------------------------
  // Statistics and registers
  // --------------------------------------------------------------------------

  // Frame ends at each stage
  always_comb begin
    stat_event = '0;
    stat_event[mac_attach_reg_pkg::STAT_RX_MAC]  = rx_frame_seen;
    stat_event[mac_attach_reg_pkg::STAT_RX_DROP] = rx_frame_drop;
    stat_event[mac_attach_reg_pkg::STAT_RX_OUT]  =
      o_pipe_rx_tvalid && i_pipe_rx_tready && o_pipe_rx_tlast;
    stat_event[mac_attach_reg_pkg::STAT_TX_IN]   =
      i_pipe_tx_tvalid && o_pipe_tx_tready && i_pipe_tx_tlast;
    stat_event[mac_attach_reg_pkg::STAT_TX_MAC]  =
      o_mac_tx_tvalid && i_mac_tx_tready && o_mac_tx_tlast;
  end

  pkt_stat_counters u_counters (
    .axis_aclk (axis_aclk),
    .i_rst_n   (i_rst_n),
    .i_event   (stat_event),
    .stat      (stat)
  );

  attach_regs u_regs (
    .axis_aclk    (axis_aclk),
    .i_rst_n      (i_rst_n),
    .i_reg_addr   (i_reg_addr),
    .i_reg_wr     (i_reg_wr),
    .i_reg_wdata  (i_reg_wdata),
    .i_reg_rd     (i_reg_rd),
    .o_reg_rdata  (o_reg_rdata),
    .o_reg_rvalid (o_reg_rvalid),
    .stat         (stat)
  );

endmodule

// ==== pkt_stat_counters.sv ====
/*
 * Packet counters with sticky overflow
 * One counter per stage event, cleared on read or on request
 */
module pkt_stat_counters (
  input  logic                                     axis_aclk,
  input  logic                                     i_rst_n,
  input  logic [mac_attach_reg_pkg::NUM_STATS-1:0] i_event,
  pkt_stat_if.counters                             stat
);

  localparam int N = mac_attach_reg_pkg::NUM_STATS;
  localparam int W = $bits(mac_attach_reg_pkg::stat_cnt_t);

  mac_attach_reg_pkg::stat_cnt_t cnt [N];

  always_ff @(posedge axis_aclk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < N; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N; i++) begin
        // Clear wins over a same-cycle event
        if (stat.clear_all || stat.read_clear[i]) begin
          cnt[i] <= '0;
        end else begin
          cnt[i][W-2:0] <= cnt[i][W-2:0] + (W - 1)'(i_event[i]);
          // Wrap of the count sets the flag for good
          if (i_event[i] && (&cnt[i][W-2:0])) begin
            cnt[i][W-1] <= 1'b1;
          end
        end
      end
    end
  end

  assign stat.count = cnt;

endmodule

// ==== pkt_stat_if.sv ====
/*
 * Counter link between the statistics block and the registers
 */
interface pkt_stat_if;

  mac_attach_reg_pkg::stat_cnt_t count [mac_attach_reg_pkg::NUM_STATS];
  // One bit per counter, pulsed on a counter read
  logic [mac_attach_reg_pkg::NUM_STATS-1:0] read_clear;
  logic clear_all;

  modport counters (
    input  read_clear,
    input  clear_all,
    output count
  );

  modport regs (
    output read_clear,
    output clear_all,
    input  count
  );

endinterface

// ==== rx_frame_queue.sv ====
/*
 * Receive frame queue
 * Holds MAC frames until the last beat, then commits or drops them
 */
`include "mac_attach_settings.svh"

module rx_frame_queue (
  input  logic                               axis_aclk,
  input  logic                               i_rst_n,
  // MAC side without back-pressure
  input  mac_attach_stream_pkg::axis_data_t  i_tdata,
  input  mac_attach_stream_pkg::axis_keep_t  i_tkeep,
  input  mac_attach_stream_pkg::axis_tuser_t i_tuser,
  input  logic                               i_tvalid,
  input  logic                               i_tlast,
  input  logic                               i_err,
  input  logic [7:0]                         i_interface_number,
  input  logic [`TIMESTAMP_WIDTH-1:0]        i_stamp,
  // Pipeline side
  output mac_attach_stream_pkg::axis_data_t  o_tdata,
  output mac_attach_stream_pkg::axis_keep_t  o_tkeep,
  output mac_attach_stream_pkg::axis_tuser_t o_tuser,
  output logic                               o_tvalid,
  output logic                               o_tlast,
  input  logic                               i_tready,
  // Statistics events
  output logic                               o_frame_seen,
  output logic                               o_frame_drop
);

  localparam int DEPTH = `RX_QUEUE_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  typedef logic [AW:0] ptr_t;

  mac_attach_stream_pkg::stream_beat_t mem [DEPTH];
  mac_attach_stream_pkg::stream_beat_t in_beat;
  mac_attach_stream_pkg::stream_beat_t out_beat;

  ptr_t wr_spec;
  ptr_t wr_commit;
  ptr_t rd_ptr;
  logic in_frame;
  logic skip_frame;
  logic spec_full;
  logic accept;
  logic overflow;
  logic mem_we;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------

  // First beat carries the port number and arrival time
  always_comb begin
    in_beat = '{data: i_tdata, keep: i_tkeep, tuser: i_tuser, last: i_tlast};
    if (!in_frame) begin
      in_beat.tuser[mac_attach_stream_pkg::TUSER_STAMP_LSB +:
                    mac_attach_stream_pkg::TUSER_STAMP_WIDTH] = i_stamp;
      in_beat.tuser[mac_attach_stream_pkg::TUSER_SRC_PORT_LSB +:
                    mac_attach_stream_pkg::TUSER_SRC_PORT_WIDTH] = i_interface_number;
    end
  end

  assign spec_full = ptr_t'(wr_spec - rd_ptr) == ptr_t'(DEPTH);
  assign accept    = i_tvalid && !skip_frame;
  assign overflow  = accept && spec_full;
  assign mem_we    = accept && !spec_full;

  assign o_frame_seen = i_tvalid && i_tlast;
  assign o_frame_drop = overflow || (mem_we && i_tlast && i_err);

  always_ff @(posedge axis_aclk) begin
    if (mem_we) begin
      mem[wr_spec[AW-1:0]] <= in_beat;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!i_rst_n) begin
      wr_spec    <= '0;
      wr_commit  <= '0;
      rd_ptr     <= '0;
      in_frame   <= 1'b0;
      skip_frame <= 1'b0;
    end else begin
      if (i_tvalid) begin
        in_frame <= !i_tlast;
      end
      if (skip_frame && i_tvalid && i_tlast) begin
        skip_frame <= 1'b0;
      end
      // Overflow rewinds and ignores the rest of the frame
      if (overflow) begin
        wr_spec    <= wr_commit;
        skip_frame <= !i_tlast;
      end else if (mem_we) begin
        if (i_tlast && i_err) begin
          wr_spec <= wr_commit;
        end else if (i_tlast) begin
          wr_spec   <= wr_spec + ptr_t'(1);
          wr_commit <= wr_spec + ptr_t'(1);
        end else begin
          wr_spec <= wr_spec + ptr_t'(1);
        end
      end
      if (o_tvalid && i_tready) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Output side shows committed beats only
  // --------------------------------------------------------------------------
  assign out_beat = mem[rd_ptr[AW-1:0]];
  assign o_tvalid = rd_ptr != wr_commit;
  assign o_tdata  = out_beat.data;
  assign o_tkeep  = out_beat.keep;
  assign o_tuser  = out_beat.tuser;
  assign o_tlast  = out_beat.last;

  a_commit_bound : assert property (@(posedge axis_aclk) disable iff (!i_rst_n)
    ptr_t'(wr_commit - rd_ptr) <= ptr_t'(DEPTH));

endmodule

// ==== tb_mac_attach.sv ====
/*
 * Testbench for the MAC attachment
 * Replays frames and register accesses from the stimulus file
 */
`include "mac_attach_settings.svh"

module tb_mac_attach;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int         TIMEOUT_CYCLES = 2000;
  localparam logic [7:0] PORT_NUMBER    = 8'h3c;

  logic                               axis_aclk;
  logic                               i_rst_n;
  mac_attach_stream_pkg::axis_data_t  i_mac_rx_tdata;
  mac_attach_stream_pkg::axis_keep_t  i_mac_rx_tkeep;
  mac_attach_stream_pkg::axis_tuser_t i_mac_rx_tuser;
  logic                               i_mac_rx_tvalid;
  logic                               i_mac_rx_tlast;
  logic                               i_mac_rx_err;
  mac_attach_stream_pkg::axis_data_t  o_pipe_rx_tdata;
  mac_attach_stream_pkg::axis_keep_t  o_pipe_rx_tkeep;
  mac_attach_stream_pkg::axis_tuser_t o_pipe_rx_tuser;
  logic                               o_pipe_rx_tvalid;
  logic                               o_pipe_rx_tlast;
  logic                               i_pipe_rx_tready;
  mac_attach_stream_pkg::axis_data_t  i_pipe_tx_tdata;
  mac_attach_stream_pkg::axis_keep_t  i_pipe_tx_tkeep;
  mac_attach_stream_pkg::axis_tuser_t i_pipe_tx_tuser;
  logic                               i_pipe_tx_tvalid;
  logic                               i_pipe_tx_tlast;
  logic                               o_pipe_tx_tready;
  mac_attach_stream_pkg::axis_data_t  o_mac_tx_tdata;
  mac_attach_stream_pkg::axis_keep_t  o_mac_tx_tkeep;
  mac_attach_stream_pkg::axis_tuser_t o_mac_tx_tuser;
  logic                               o_mac_tx_tvalid;
  logic                               o_mac_tx_tlast;
  logic                               i_mac_tx_tready;
  logic [7:0]                         i_interface_number;
  logic [`TIMESTAMP_WIDTH-1:0]        i_stamp_counter;
  mac_attach_reg_pkg::reg_addr_t      i_reg_addr;
  logic                               i_reg_wr;
  mac_attach_reg_pkg::reg_data_t      i_reg_wdata;
  logic                               i_reg_rd;
  mac_attach_reg_pkg::reg_data_t      o_reg_rdata;
  logic                               o_reg_rvalid;

  logic [15:0] lfsr;
  logic        ready_toggle;
  mac_attach_stream_pkg::stream_beat_t rx_exp [$];
  mac_attach_stream_pkg::stream_beat_t tx_exp [$];

  mac_attach_top DUT (.*);

  always #20 axis_aclk = ~axis_aclk;

  // --------------------------------------------------------------------------
  // Reporting and compare tasks
  // --------------------------------------------------------------------------
  task automatic stop_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_beat(string name, mac_attach_stream_pkg::stream_beat_t got,
                            mac_attach_stream_pkg::stream_beat_t exp);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_reg(string name, mac_attach_reg_pkg::reg_data_t got,
                           mac_attach_reg_pkg::reg_data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // Random source and beat builder
  // --------------------------------------------------------------------------

  // Galois form with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] take_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic mac_attach_stream_pkg::stream_beat_t make_beat(logic last);
    mac_attach_stream_pkg::stream_beat_t b;
    b.data  = take_bits(64);
    b.keep  = last ? mac_attach_stream_pkg::axis_keep_t'(8'hff >> take_bits(3)) : 8'hff;
    b.tuser = {take_bits(64), take_bits(64)};
    b.last  = last;
    return b;
  endfunction

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge axis_aclk);
    #2;
    i_stamp_counter = i_stamp_counter + `TIMESTAMP_WIDTH'(1);
    if (ready_toggle) begin
      i_mac_tx_tready = 1'(take_bits(1));
    end else begin
      i_mac_tx_tready = 1'b1;
    end
  endtask

  task automatic drain_queues();
    int waited;
    waited = 0;
    while (rx_exp.size() != 0 || tx_exp.size() != 0) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_run("expected frames never left the stream outputs");
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------------------------------
  task automatic send_rx_frame(logic [31:0] len, logic [31:0] err, logic [31:0] seed);
    mac_attach_stream_pkg::stream_beat_t beat;
    lfsr = seed[15:0];
    for (int i = 0; i < len; i++) begin
      beat            = make_beat(i == len - 1);
      i_mac_rx_tdata  = beat.data;
      i_mac_rx_tkeep  = beat.keep;
      i_mac_rx_tuser  = beat.tuser;
      i_mac_rx_tlast  = beat.last;
      i_mac_rx_err    = err[0] && beat.last;
      i_mac_rx_tvalid = 1'b1;
      // Time base is registered once, so the first beat sees last cycle's value
      if (i == 0) begin
        beat.tuser[mac_attach_stream_pkg::TUSER_STAMP_LSB +:
                   mac_attach_stream_pkg::TUSER_STAMP_WIDTH] =
          i_stamp_counter - `TIMESTAMP_WIDTH'(1);
        beat.tuser[mac_attach_stream_pkg::TUSER_SRC_PORT_LSB +:
                   mac_attach_stream_pkg::TUSER_SRC_PORT_WIDTH] = PORT_NUMBER;
      end
      if (!err[0]) begin
        rx_exp.push_back(beat);
      end
      next_cycle();
    end
    i_mac_rx_tvalid = 1'b0;
    i_mac_rx_tlast  = 1'b0;
    i_mac_rx_err    = 1'b0;
  endtask

  task automatic drive_tx_beat(mac_attach_stream_pkg::stream_beat_t beat);
    int   waited;
    logic taken;
    waited           = 0;
    taken            = 1'b0;
    i_pipe_tx_tdata  = beat.data;
    i_pipe_tx_tkeep  = beat.keep;
    i_pipe_tx_tuser  = beat.tuser;
    i_pipe_tx_tlast  = beat.last;
    i_pipe_tx_tvalid = 1'b1;
    tx_exp.push_back(beat);
    while (!taken) begin
      taken = o_pipe_tx_tready;
      next_cycle();
      waited++;
      if (!taken && waited > TIMEOUT_CYCLES) begin
        stop_run("transmit queue never accepted a beat");
      end
    end
  endtask

  task automatic send_tx_frames(logic [31:0] count, logic [31:0] len, logic [31:0] mode,
                                logic [31:0] seed);
    lfsr         = seed[15:0];
    ready_toggle = mode[0];
    for (int f = 0; f < count; f++) begin
      for (int i = 0; i < len; i++) begin
        drive_tx_beat(make_beat(i == len - 1));
      end
    end
    i_pipe_tx_tvalid = 1'b0;
    drain_queues();
    ready_toggle = 1'b0;
  endtask

  task automatic reg_write(logic [31:0] addr, logic [31:0] data);
    drain_queues();
    i_reg_addr  = mac_attach_reg_pkg::reg_addr_t'(addr);
    i_reg_wdata = data;
    i_reg_wr    = 1'b1;
    next_cycle();
    i_reg_wr = 1'b0;
  endtask

  task automatic reg_read(logic [31:0] addr, logic [31:0] expected);
    int waited;
    waited = 0;
    drain_queues();
    i_reg_addr = mac_attach_reg_pkg::reg_addr_t'(addr);
    i_reg_rd   = 1'b1;
    next_cycle();
    i_reg_rd = 1'b0;
    while (!o_reg_rvalid) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_run("register read got no response");
      end
    end
    check_reg($sformatf("o_reg_rdata at address %h", addr[7:0]), o_reg_rdata, expected);
  endtask

  // --------------------------------------------------------------------------
  // Output monitors sample half a cycle before the transfer edge
  // --------------------------------------------------------------------------
  always @(negedge axis_aclk) begin : rx_monitor
    mac_attach_stream_pkg::stream_beat_t got;
    if (i_rst_n && o_pipe_rx_tvalid && i_pipe_rx_tready) begin
      got = '{data: o_pipe_rx_tdata, keep: o_pipe_rx_tkeep, tuser: o_pipe_rx_tuser,
              last: o_pipe_rx_tlast};
      if (rx_exp.size() == 0) begin
        stop_run("a beat left the receive output with no good frame pending");
      end else begin
        check_beat("o_pipe_rx beat", got, rx_exp.pop_front());
      end
    end
  end

  always @(negedge axis_aclk) begin : tx_monitor
    mac_attach_stream_pkg::stream_beat_t got;
    if (i_rst_n && o_mac_tx_tvalid && i_mac_tx_tready) begin
      got = '{data: o_mac_tx_tdata, keep: o_mac_tx_tkeep, tuser: o_mac_tx_tuser,
              last: o_mac_tx_tlast};
      if (tx_exp.size() == 0) begin
        stop_run("a beat left the MAC transmit output with no frame pending");
      end else begin
        check_beat("o_mac_tx beat", got, tx_exp.pop_front());
      end
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] op;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    axis_aclk          = 1'b0;
    i_rst_n            = 1'b0;
    i_mac_rx_tdata     = '0;
    i_mac_rx_tkeep     = '0;
    i_mac_rx_tuser     = '0;
    i_mac_rx_tvalid    = 1'b0;
    i_mac_rx_tlast     = 1'b0;
    i_mac_rx_err       = 1'b0;
    i_pipe_rx_tready   = 1'b1;
    i_pipe_tx_tdata    = '0;
    i_pipe_tx_tkeep    = '0;
    i_pipe_tx_tuser    = '0;
    i_pipe_tx_tvalid   = 1'b0;
    i_pipe_tx_tlast    = 1'b0;
    i_mac_tx_tready    = 1'b1;
    i_interface_number = PORT_NUMBER;
    i_stamp_counter    = 64'h0123_4567_0000_0000;
    i_reg_addr         = '0;
    i_reg_wr           = 1'b0;
    i_reg_wdata        = '0;
    i_reg_rd           = 1'b0;
    lfsr               = 16'd56;
    ready_toggle       = 1'b0;

    repeat (10) next_cycle();
    i_rst_n = 1'b1;
    check_flag("o_pipe_rx_tvalid", o_pipe_rx_tvalid, 1'b0);
    check_flag("o_mac_tx_tvalid", o_mac_tx_tvalid, 1'b0);
    check_flag("o_reg_rvalid", o_reg_rvalid, 1'b0);
    check_flag("o_pipe_tx_tready", o_pipe_tx_tready, 1'b1);

    fd = $fopen("mac_attach_stimulus.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open the stimulus file");
    end
    // Comment lines do not parse as four hex fields
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%h %h %h %h", op, f1, f2, f3);
      if (n == 4) begin
        case (op)
          32'h1:   send_rx_frame(f1, f2, f3);
          32'h2:   send_tx_frames(32'd1, f1, f2, f3);
          32'h3:   reg_write(f1, f2);
          32'h4:   reg_read(f1, f2);
          32'h5:   send_tx_frames(f1, 32'd1, f2, f3);
          default: stop_run("unknown operation code in the stimulus file");
        endcase
      end
    end
    $fclose(fd);
    drain_queues();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== tx_frame_queue.sv ====
/*
 * Transmit frame FIFO between the pipeline and the MAC
 */
`include "mac_attach_settings.svh"

module tx_frame_queue (
  input  logic                               axis_aclk,
  input  logic                               i_rst_n,
  input  mac_attach_stream_pkg::axis_data_t  i_tdata,
  input  mac_attach_stream_pkg::axis_keep_t  i_tkeep,
  input  mac_attach_stream_pkg::axis_tuser_t i_tuser,
  input  logic                               i_tvalid,
  input  logic                               i_tlast,
  output logic                               o_tready,
  output mac_attach_stream_pkg::axis_data_t  o_tdata,
  output mac_attach_stream_pkg::axis_keep_t  o_tkeep,
  output mac_attach_stream_pkg::axis_tuser_t o_tuser,
  output logic                               o_tvalid,
  output logic                               o_tlast,
  input  logic                               i_tready
);

  localparam int DEPTH = `TX_QUEUE_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  mac_attach_stream_pkg::stream_beat_t mem [DEPTH];
  mac_attach_stream_pkg::stream_beat_t out_beat;

  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] level;
  logic        wr_en;
  logic        rd_en;

  assign level    = wr_ptr - rd_ptr;
  assign o_tready = level != (AW + 1)'(DEPTH);
  assign o_tvalid = level != '0;
  assign wr_en    = i_tvalid && o_tready;
  assign rd_en    = o_tvalid && i_tready;

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= '{data: i_tdata, keep: i_tkeep, tuser: i_tuser, last: i_tlast};
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr + (AW + 1)'(wr_en);
      rd_ptr <= rd_ptr + (AW + 1)'(rd_en);
    end
  end

  assign out_beat = mem[rd_ptr[AW-1:0]];
  assign o_tdata  = out_beat.data;
  assign o_tkeep  = out_beat.keep;
  assign o_tuser  = out_beat.tuser;
  assign o_tlast  = out_beat.last;

  // A write into a full queue would overwrite the held head beat
  a_no_write_full : assert property (@(posedge axis_aclk) disable iff (!i_rst_n)
    o_tvalid && !i_tready |=> o_tvalid && $stable(out_beat));
  // A read from an empty queue would push the level past the depth
  a_no_read_empty : assert property (@(posedge axis_aclk) disable iff (!i_rst_n)
    level <= (AW + 1)'(DEPTH));

endmodule
